// ==== design/branch_predictor.sv ====
// Branch predictor
// Sixteen 2-bit saturating direction counters plus a 16-entry BTB
// Read combinationally by fetch, trained by decode one branch at a time
`default_nettype none

module branch_predictor (
  input  logic                    clk,
  input  logic                    rst,
  input  cpu_fetch_pkg::pred_idx_t lookup_idx,        // Low bits of fetch PC
  output cpu_fetch_pkg::pred_t     prediction,        // Counter at lookup_idx
  output cpu_fetch_pkg::addr_t     predicted_target,  // BTB target at lookup_idx
  output logic                    btb_hit,           // BTB entry valid
  input  cpu_fetch_pkg::resolve_t  update             // Training pulse from decode
);

  import cpu_fetch_pkg::*;

  pred_t                   ctr        [PRED_ENTRIES];  // Direction counters
  addr_t                   btb_target [PRED_ENTRIES];  // Target payload
  logic [PRED_ENTRIES-1:0] btb_valid;                  // One valid bit per entry
  pred_t                   ctr_cur;                    // Counter being trained
  pred_t                   ctr_next;                   // Its saturated new value

  ////////////////////////////////
  // Lookup, same cycle as fetch
  ////////////////////////////////
  assign prediction       = ctr[lookup_idx];
  assign predicted_target = btb_target[lookup_idx];
  assign btb_hit          = btb_valid[lookup_idx];

  ////////////////////////////////
  // Training
  ////////////////////////////////
  assign ctr_cur = ctr[update.idx];

  // Saturating step, up on taken and down on not taken
  always_comb begin
    ctr_next = ctr_cur;
    if (update.taken) begin
      if (ctr_cur != 2'b11)
        ctr_next = ctr_cur + 2'b01;
    end else if (ctr_cur != 2'b00) begin
      ctr_next = ctr_cur - 2'b01;
    end
  end

  // Counters and valid bits come out of reset known
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < PRED_ENTRIES; i++) begin
        ctr[i] <= PRED_RESET;
      end
      btb_valid <= '0;
    end else if (update.valid) begin
      ctr[update.idx] <= ctr_next;
      if (update.taken)
        btb_valid[update.idx] <= 1'b1;     // Entry becomes usable for fetch
    end
  end

  // Target storage, only meaningful once the valid bit is set
  always_ff @(posedge clk) begin
    if (update.valid && update.taken)
      btb_target[update.idx] <= update.target;
  end

  // Decode hands us a clean index whenever it trains
  a_update_idx_known: assert property (@(posedge clk) disable iff (rst)
    update.valid |-> !$isunknown(update.idx))
    else $error("branch_predictor: training pulse with unknown index");

endmodule

`default_nettype wire

// ==== design/cpu_fetch_pkg.sv ====
// CPU front-end package
// ISA widths, branch opcode, predictor constants and the structs passed
// between fetch, the IF/ID register and the decode-side branch resolver
`default_nettype none

package cpu_fetch_pkg;

  ////////////////////////////////
  // Widths and ISA constants
  ////////////////////////////////
  localparam int ADDR_W       = 16;       // Word-addressed instruction space
  localparam int INST_W       = 16;       // Instruction word
  localparam int PRED_ENTRIES = 16;       // Counters and BTB entries
  localparam int PRED_IDX_W   = $clog2(PRED_ENTRIES);
  localparam int OFFSET_W     = 9;        // Signed branch offset in inst[8:0]

  localparam logic [3:0] OPC_BRANCH = 4'hC;   // Opcode field inst[15:12]

  typedef logic [ADDR_W-1:0]     addr_t;      // Instruction address
  typedef logic [INST_W-1:0]     inst_t;      // Instruction word
  typedef logic [1:0]            pred_t;      // 2-bit counter, MSB = taken
  typedef logic [PRED_IDX_W-1:0] pred_idx_t;  // Low PC bits into the tables

  localparam pred_t PRED_RESET = 2'b01;   // Weakly not taken

  ////////////////////////////////
  // Stage payloads
  ////////////////////////////////
  // Fetch -> IF/ID, 66 bits
  typedef struct packed {
    addr_t pc_curr;            // PC of the fetched word
    addr_t pc_next;            // PC + 1, base for branch offsets
    inst_t inst;               // Word from instruction memory
    pred_t prediction;         // Counter value at fetch time
    addr_t predicted_target;   // BTB target, or PC + 1 on a miss
  } fetch_t;

  // IF/ID -> decode, 54 bits
  typedef struct packed {
    pred_idx_t pc_idx;         // Only the table index is kept
    addr_t     pc_next;
    inst_t     inst;
    pred_t     prediction;
    addr_t     predicted_target;
  } if_id_t;

  // Decode -> predictor training pulse, 22 bits
  typedef struct packed {
    logic      valid;          // One cycle per resolved branch
    pred_idx_t idx;
    logic      taken;
    addr_t     target;
  } resolve_t;

endpackage

`default_nettype wire

// ==== design/decode_branch_unit.sv ====
// Decode-side branch resolver
// Spots branches in IF/ID, computes the real target, checks it against the
// fetch-time prediction and emits redirect and training
`default_nettype none

module decode_branch_unit (
  input  logic                    hold,         // Hazard stall, blocks resolution
  input  cpu_fetch_pkg::if_id_t    if_id,
  input  logic                    cond_met,     // Real branch outcome
  output logic                    redirect,     // Mispredict, also flushes IF/ID
  output cpu_fetch_pkg::addr_t     redirect_pc,
  output cpu_fetch_pkg::resolve_t  resolve       // Training pulse
);

  import cpu_fetch_pkg::*;

  logic                is_branch;     // Opcode match
  logic [OFFSET_W-1:0] offset;        // Raw signed offset
  addr_t               offset_ext;    // Sign-extended to address width
  addr_t               target;        // Real taken target
  logic                taken;
  logic                pred_taken;    // Counter MSB from fetch time
  logic                dir_wrong;
  logic                tgt_wrong;
  logic                mispredict;
  logic                resolve_now;   // A branch is being resolved this cycle

  ////////////////////////////////
  // Branch decode and target
  ////////////////////////////////
  assign is_branch  = (if_id.inst[15:12] == OPC_BRANCH);
  assign offset     = if_id.inst[OFFSET_W-1:0];
  assign offset_ext = {{(ADDR_W-OFFSET_W){offset[OFFSET_W-1]}}, offset};
  assign target     = if_id.pc_next + offset_ext;   // Relative to PC + 1

  ////////////////////////////////
  // Prediction check
  ////////////////////////////////
  assign taken      = cond_met;
  assign pred_taken = if_id.prediction[1];

  // Wrong direction, or right direction but fetch went somewhere else
  assign dir_wrong  = (taken != pred_taken);
  assign tgt_wrong  = taken && (if_id.predicted_target != target);
  assign mispredict = dir_wrong || tgt_wrong;

  // Nothing resolves under hold, the same branch is seen again afterwards
  assign resolve_now = is_branch && !hold;

  ////////////////////////////////
  // Outputs
  ////////////////////////////////
  assign redirect    = resolve_now && mispredict;
  assign redirect_pc = taken ? target : if_id.pc_next;   // Not taken falls through

  assign resolve = '{valid:  resolve_now,
                     idx:    if_id.pc_idx,
                     taken:  taken,
                     target: target};

  // A resolving branch needs a known outcome to train and redirect on
  always_comb begin
    a_outcome_known: assert #0 (!resolve.valid || !$isunknown(cond_met))
      else $error("decode_branch_unit: branch resolved with unknown cond_met");
  end

endmodule

`default_nettype wire

// ==== design/fetch_decode_top.sv ====
// CPU front end
// Fetch with branch prediction, the IF/ID register and the decode-side
// branch resolver wired into one block
`default_nettype none

module fetch_decode_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  hold,         // External hazard stall
  input  logic                  cond_met,     // Outcome of the branch in IF/ID
  output cpu_fetch_pkg::addr_t   imem_addr,
  input  cpu_fetch_pkg::inst_t   imem_data,
  output cpu_fetch_pkg::if_id_t  if_id,
  output logic                  redirect,
  output cpu_fetch_pkg::addr_t   redirect_pc
);

  import cpu_fetch_pkg::*;

  fetch_t   fetch_w;     // Fetch payload into IF/ID
  resolve_t resolve_w;   // Training back to the predictor

  fetch_stage fetch0 (
    .clk         (clk),
    .rst         (rst),
    .hold        (hold),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .update      (resolve_w),
    .fetch       (fetch_w)
  );

  // Redirect doubles as the flush, so the wrong-path word becomes a bubble
  if_id_pipe_reg if_id0 (
    .clk   (clk),
    .rst   (rst),
    .stall (hold),
    .flush (redirect),
    .fetch (fetch_w),
    .if_id (if_id)
  );

  decode_branch_unit decode0 (
    .hold        (hold),
    .if_id       (if_id),
    .cond_met    (cond_met),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .resolve     (resolve_w)
  );

endmodule

`default_nettype wire

// ==== design/fetch_stage.sv ====
// Instruction fetch stage
// Holds the PC, picks the next PC from redirect, prediction or PC + 1,
// and bundles the fetched word with its prediction for IF/ID
`default_nettype none

module fetch_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    hold,         // Freezes the PC
  output cpu_fetch_pkg::addr_t     imem_addr,    // Current PC to instruction memory
  input  cpu_fetch_pkg::inst_t     imem_data,    // Same-cycle read data
  input  logic                    redirect,     // Mispredict from decode
  input  cpu_fetch_pkg::addr_t     redirect_pc,  // Corrected fetch address
  input  cpu_fetch_pkg::resolve_t  update,       // Predictor training
  output cpu_fetch_pkg::fetch_t    fetch         // Payload into IF/ID
);

  import cpu_fetch_pkg::*;

  addr_t pc_q;          // Program counter
  addr_t pc_plus1;      // Sequential successor
  addr_t pc_d;          // Selected next PC
  pred_t prediction;    // Counter at the current PC
  addr_t btb_target;    // Raw BTB entry
  logic  btb_hit;
  addr_t pred_target;   // Where fetch believes this word leads
  logic  follow_btb;    // Predicted taken with a usable target

  branch_predictor predictor0 (
    .clk              (clk),
    .rst              (rst),
    .lookup_idx       (pc_q[PRED_IDX_W-1:0]),
    .prediction       (prediction),
    .predicted_target (btb_target),
    .btb_hit          (btb_hit),
    .update           (update)
  );

  ////////////////////////////////
  // Next-PC selection
  ////////////////////////////////
  assign pc_plus1    = pc_q + addr_t'(1);
  assign pred_target = btb_hit ? btb_target : pc_plus1;   // Miss falls through
  assign follow_btb  = prediction[1] && btb_hit;

  always_comb begin
    if (redirect)
      pc_d = redirect_pc;        // Decode correction wins
    else if (follow_btb)
      pc_d = btb_target;
    else
      pc_d = pc_plus1;
  end

  always_ff @(posedge clk) begin
    if (rst)
      pc_q <= '0;
    else if (!hold)
      pc_q <= pc_d;
  end

  assign imem_addr = pc_q;

  // Everything decode needs to check this word's prediction later
  assign fetch = '{pc_curr:          pc_q,
                   pc_next:          pc_plus1,
                   inst:             imem_data,
                   prediction:       prediction,
                   predicted_target: pred_target};

endmodule

`default_nettype wire

// ==== design/if_id_pipe_reg.sv ====
// IF/ID pipeline register
// Captures the fetch payload each cycle, holds on stall, and turns the
// slot into a bubble on flush
`default_nettype none

module if_id_pipe_reg (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  stall,   // Keep current contents
  input  logic                  flush,   // Drop the word, wins over stall
  input  cpu_fetch_pkg::fetch_t  fetch,
  output cpu_fetch_pkg::if_id_t  if_id
);

  import cpu_fetch_pkg::*;

  logic      wen;                 // Load enable
  logic      clr;                 // Bubble or reset
  pred_idx_t pc_idx_q;
  addr_t     pc_next_q;
  inst_t     inst_q;
  pred_t     prediction_q;
  addr_t     predicted_target_q;

  assign wen = ~stall;
  assign clr = flush | rst;

  // PC bookkeeping survives a flush, only reset clears it
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_idx_q  <= '0;
      pc_next_q <= '0;
    end else if (wen) begin
      pc_idx_q  <= fetch.pc_curr[PRED_IDX_W-1:0];
      pc_next_q <= fetch.pc_next;
    end
  end

  // Word and prediction, zeroed to form a bubble
  always_ff @(posedge clk) begin
    if (clr) begin
      inst_q             <= '0;
      prediction_q       <= '0;
      predicted_target_q <= '0;
    end else if (wen) begin
      inst_q             <= fetch.inst;
      prediction_q       <= fetch.prediction;
      predicted_target_q <= fetch.predicted_target;
    end
  end

  assign if_id = '{pc_idx:           pc_idx_q,
                   pc_next:          pc_next_q,
                   inst:             inst_q,
                   prediction:       prediction_q,
                   predicted_target: predicted_target_q};

  // Decode never resolves while the pipe is held
  a_no_flush_in_stall: assert property (@(posedge clk) disable iff (rst)
    !(flush && stall))
    else $error("if_id_pipe_reg: flush raised during stall");

endmodule

`default_nettype wire

// ==== sim.f ====
design/cpu_fetch_pkg.sv
design/branch_predictor.sv
design/fetch_stage.sv
design/if_id_pipe_reg.sv
design/decode_branch_unit.sv
design/fetch_decode_top.sv
sim/clk_rst_gen.sv
sim/fetch_decode_tb.sv

// ==== sim/clk_rst_gen.sv ====
// Testbench clock and reset
// 4 ns clock, reset held high for the first 16 rising edges
`default_nettype none

module clk_rst_gen (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 2;    // 4 ns period
  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;   // Released off the edge, like the other inputs
  end

endmodule

`default_nettype wire

// ==== sim/fetch_decode_tb.sv ====
// Testbench for the CPU front end
// Runs a small loop program through fetch, IF/ID and decode, and checks
// each cycle against a reference model of the PC, predictor and IF/ID
`default_nettype none

module fetch_decode_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import cpu_fetch_pkg::*;

  localparam int    MEM_WORDS    = 64;
  localparam addr_t LOOP_PC      = 16'd10;    // Backward branch, target 5
  localparam inst_t LOOP_BRANCH  = 16'hC1FA;  // Opcode C, offset -6
  localparam int    N_TESTS      = 6;
  localparam int    RESET_CYCLES = 16;
  localparam int    MARGIN       = 20;

  typedef struct packed {
    logic [8*12-1:0] name;        // ASCII test name
    logic            hold;
    logic            cond;
    int              cycles;
    int              redirects;   // Mispredicts expected in the row
    int              bubbles;     // Empty IF/ID slots expected in the row
  } test_row_t;

  // Cycle positions follow from the 6-word loop body at 5..10
  test_row_t tests [N_TESTS] = '{
    '{"straight",    1'b0, 1'b0,  8, 0, 1},   // Cycle 0 still shows the reset slot
    '{"first_taken", 1'b0, 1'b1,  6, 1, 1},   // Counter at 01, BTB cold
    '{"loop",        1'b0, 1'b1, 16, 0, 0},   // Trained, fetch follows the BTB
    '{"hold",        1'b1, 1'b0,  4, 0, 0},   // Branch parked in IF/ID
    '{"not_taken",   1'b0, 1'b0,  6, 1, 1},   // Counter at 11 is now wrong
    '{"exit",        1'b0, 1'b0, 10, 0, 0}    // Straight code past the loop
  };

  logic   clk;
  logic   rst;
  logic   hold     = 1'b1;   // Keeps decode quiet until IF/ID is cleared
  logic   cond_met = 1'b0;
  addr_t  imem_addr;
  inst_t  imem_data;
  if_id_t if_id;
  logic   redirect;
  addr_t  redirect_pc;

  inst_t  prog_mem [MEM_WORDS];   // Program image

  ////////////////////////////////
  // Reference model state
  ////////////////////////////////
  addr_t  m_pc;
  pred_t  m_ctr     [PRED_ENTRIES];
  addr_t  m_btb_tgt [PRED_ENTRIES];
  logic   m_btb_val [PRED_ENTRIES];
  if_id_t m_if_id;
  logic   exp_redirect;
  addr_t  exp_redirect_pc;

  int error_count = 0;
  int row_errors  = 0;
  int check_count = 0;
  int cycle_count = 0;
  int cycle_limit = RESET_CYCLES + MARGIN;

  clk_rst_gen clk_gen0 (
    .clk (clk),
    .rst (rst)
  );

  fetch_decode_top dut0 (
    .clk         (clk),
    .rst         (rst),
    .hold        (hold),
    .cond_met    (cond_met),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .if_id       (if_id),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  assign imem_data = prog_mem[imem_addr[5:0]];   // Combinational read, wraps at 64

  function automatic logic is_branch(input inst_t w);
    return w[15:12] == OPC_BRANCH;
  endfunction

  // pc_next plus the signed 9-bit offset
  function automatic addr_t branch_target(input if_id_t s);
    addr_t off;
    off = {{(ADDR_W-OFFSET_W){s.inst[OFFSET_W-1]}}, s.inst[OFFSET_W-1:0]};
    return s.pc_next + off;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("FAIL t=%0t ns %s: got %0h, expected %0h", $time, what, got, exp);
      error_count++;
      row_errors++;
    end
  endtask

  task automatic reset_model();
    m_pc    = '0;
    m_if_id = '0;
    for (int i = 0; i < PRED_ENTRIES; i++) begin
      m_ctr[i]     = PRED_RESET;
      m_btb_tgt[i] = '0;
      m_btb_val[i] = 1'b0;
    end
  endtask

  // Decode view of the slot in IF/ID for the cycle in progress
  task automatic predict_outputs(input logic h, input logic c);
    addr_t tgt;
    logic  mis;
    tgt = branch_target(m_if_id);
    mis = (c != m_if_id.prediction[1]) || (c && (m_if_id.predicted_target != tgt));
    exp_redirect    = is_branch(m_if_id.inst) && !h && mis;
    exp_redirect_pc = c ? tgt : m_if_id.pc_next;
  endtask

  // State after the coming rising edge
  task automatic advance_model(input logic h, input logic c);
    pred_idx_t idx;
    pred_idx_t bidx;
    addr_t     plus1;
    addr_t     ptgt;
    addr_t     nxt;
    pred_t     pred;
    if (!h) begin
      idx   = m_pc[PRED_IDX_W-1:0];
      plus1 = m_pc + 16'd1;
      ptgt  = m_btb_val[idx] ? m_btb_tgt[idx] : plus1;   // Miss falls through
      pred  = m_ctr[idx];                                 // Seen before this edge trains

      // Redirect first, then a taken prediction with a BTB hit
      if (exp_redirect)
        nxt = exp_redirect_pc;
      else if (m_ctr[idx][1] && m_btb_val[idx])
        nxt = m_btb_tgt[idx];
      else
        nxt = plus1;

      // Training by the branch leaving IF/ID
      if (is_branch(m_if_id.inst)) begin
        bidx = m_if_id.pc_idx;
        if (c && m_ctr[bidx] != 2'b11)
          m_ctr[bidx] = m_ctr[bidx] + 2'b01;
        else if (!c && m_ctr[bidx] != 2'b00)
          m_ctr[bidx] = m_ctr[bidx] - 2'b01;
        if (c) begin
          m_btb_tgt[bidx] = branch_target(m_if_id);
          m_btb_val[bidx] = 1'b1;
        end
      end

      // Flush keeps only the PC fields of the captured word
      m_if_id.pc_idx  = idx;
      m_if_id.pc_next = plus1;
      if (exp_redirect) begin
        m_if_id.inst             = '0;
        m_if_id.prediction       = '0;
        m_if_id.predicted_target = '0;
      end else begin
        m_if_id.inst             = prog_mem[m_pc[5:0]];
        m_if_id.prediction       = pred;
        m_if_id.predicted_target = ptgt;
      end
      m_pc = nxt;
    end
  endtask

  ////////////////////////////////
  // Watchdog
  ////////////////////////////////
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////
  initial begin
    int redirects;
    int bubbles;
    for (int a = 0; a < MEM_WORDS; a++)
      prog_mem[a] = 16'h1000 + inst_t'(a) * 16'h0101;   // Opcode 1..4, never a branch
    prog_mem[LOOP_PC] = LOOP_BRANCH;
    for (int t = 0; t < N_TESTS; t++)
      cycle_limit += tests[t].cycles;
    reset_model();

    @(posedge clk);
    #1 hold = 1'b0;              // IF/ID is clear after the first reset edge
    wait (rst === 1'b0);

    // Reset state
    row_errors = 0;
    check_value("imem_addr", imem_addr, 16'd0);
    check_value("if_id", if_id, '0);
    check_value("redirect", redirect, 1'b0);
    $display("test reset: %0d errors", row_errors);

    for (int t = 0; t < N_TESTS; t++) begin
      row_errors = 0;
      redirects  = 0;
      bubbles    = 0;
      for (int n = 0; n < tests[t].cycles; n++) begin
        hold     = tests[t].hold;
        cond_met = tests[t].cond;
        #1;
        predict_outputs(hold, cond_met);
        check_value("imem_addr", imem_addr, m_pc);
        check_value("if_id.inst", if_id.inst, m_if_id.inst);
        check_value("if_id", if_id, m_if_id);
        check_value("redirect", redirect, exp_redirect);
        check_value("redirect_pc", redirect_pc, exp_redirect_pc);
        if (redirect)
          redirects++;
        if (if_id.inst == '0)
          bubbles++;              // Bubble or reset slot
        advance_model(hold, cond_met);
        @(posedge clk);
        #1;
      end
      check_value("redirect count", redirects, tests[t].redirects);
      check_value("bubble count", bubbles, tests[t].bubbles);
      $display("test %0s: %0d cycles, %0d redirects, %0d bubbles, %0d errors",
               tests[t].name, tests[t].cycles, redirects, bubbles, row_errors);
    end

    $display("%0d tests, %0d checks, %0d errors", N_TESTS + 1, check_count, error_count);
    if (error_count == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire
